// File: common/ifq_defines.svh
`ifndef IFQ_DEFINES_SVH
`define IFQ_DEFINES_SVH

// Instruction queue geometry
`define IFQ_DEPTH     16
`define IFQ_PTR_W     4

// Fetch starts here out of reset
`define IFQ_RESET_PC  32'h0000_0000

// Primary opcode field of an instruction word
`define IFQ_OP_MSB    31
`define IFQ_OP_LSB    26

`endif

// File: common/ifq_pkg.sv
`include "ifq_defines.svh"

package ifq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Queue pointer that also serves as an entry count
    typedef logic [`IFQ_PTR_W-1:0] qptr_t;

    // Opcodes that carry a delay slot
    typedef enum logic [5:0] {
        OP_REGIMM = 6'b000001,
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111
    } opcode_e;

endpackage

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps

`include "ifq_defines.svh"

module fetch_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            full,
    input  logic            redirect,
    input  ifq_pkg::addr_t  redirect_pc,
    input  ifq_pkg::word_t  imem_data1,
    input  ifq_pkg::word_t  imem_data2,
    output ifq_pkg::addr_t  imem_addr,
    output logic            write_en1,
    output logic            write_en2,
    output ifq_pkg::word_t  write_data1,
    output ifq_pkg::word_t  write_data2,
    output ifq_pkg::addr_t  write_address1,
    output ifq_pkg::addr_t  write_address2
);

    ifq_pkg::addr_t pc;
    ifq_pkg::addr_t pc_next_pair;
    logic           active;
    logic           odd_word;

    // Low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    assign odd_word     = pc[2];
    assign pc_next_pair = {pc[31:3] + 29'd1, 3'b000};

    assign imem_addr = pc;

    // Memory answers with the words at pc and pc+4
    assign write_data1    = imem_data1;
    assign write_data2    = imem_data2;
    assign write_address1 = pc;
    assign write_address2 = pc + 32'd4;

    // Odd-word pc writes a single word so the next request is aligned
    assign write_en1 = active && !full && !redirect;
    assign write_en2 = write_en1 && !odd_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `IFQ_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (write_en1) begin
            pc <= pc_next_pair;
        end
    end

endmodule

// File: fetch/instruction_fifo.sv
`timescale 1ns/1ps

`include "ifq_defines.svh"

module instruction_fifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            write_en1,
    input  logic            write_en2,
    input  ifq_pkg::word_t  write_data1,
    input  ifq_pkg::word_t  write_data2,
    input  ifq_pkg::addr_t  write_address1,
    input  ifq_pkg::addr_t  write_address2,
    input  logic            read_en1,
    input  logic            read_en2,
    input  logic            master_is_branch,
    output ifq_pkg::word_t  data_out1,
    output ifq_pkg::word_t  data_out2,
    output ifq_pkg::addr_t  address_out1,
    output ifq_pkg::addr_t  address_out2,
    output logic            delay_slot_out1,
    output logic            empty,
    output logic            almost_empty,
    output logic            full
);

    ifq_pkg::word_t data_mem [`IFQ_DEPTH];
    ifq_pkg::addr_t addr_mem [`IFQ_DEPTH];

    ifq_pkg::qptr_t wr_ptr;
    ifq_pkg::qptr_t rd_ptr;
    ifq_pkg::qptr_t count;
    ifq_pkg::qptr_t rd_ptr_plus1;

    // Delay slot kept across a flush
    logic           hold_valid;
    logic           hold_wait;
    ifq_pkg::word_t hold_data;
    ifq_pkg::addr_t hold_addr;

    logic           last_branch;
    logic           capture;
    logic           wa_en;
    logic           wb_en;
    ifq_pkg::word_t wa_data;
    ifq_pkg::addr_t wa_addr;
    logic           q_rd1;
    logic           q_rd2;
    logic [1:0]     n_wr;
    logic [1:0]     n_rd;

    assign rd_ptr_plus1 = rd_ptr + ifq_pkg::qptr_t'(1);

    assign full = count >= ifq_pkg::qptr_t'(`IFQ_DEPTH - 2);

    // A waiting holding register takes the first word of the next write
    assign capture = hold_wait && write_en1;
    assign wa_en   = capture ? write_en2 : write_en1;
    assign wb_en   = !capture && write_en2;
    assign wa_data = capture ? write_data2 : write_data1;
    assign wa_addr = capture ? write_address2 : write_address1;

    // Reads of the holding register do not touch the queue
    assign q_rd1 = read_en1 && !hold_valid;
    assign q_rd2 = read_en2 && !hold_valid;

    assign n_wr = {1'b0, wa_en} + {1'b0, wb_en};
    assign n_rd = {1'b0, q_rd1} + {1'b0, q_rd2};

    always_comb begin
        data_out1       = '0;
        data_out2       = '0;
        address_out1    = '0;
        address_out2    = '0;
        delay_slot_out1 = 1'b0;
        empty           = 1'b1;
        almost_empty    = 1'b0;
        if (hold_valid) begin
            data_out1       = hold_data;
            address_out1    = hold_addr;
            delay_slot_out1 = 1'b1;
            empty           = 1'b0;
            almost_empty    = 1'b1;
        end else if (count != '0) begin
            data_out1       = data_mem[rd_ptr];
            address_out1    = addr_mem[rd_ptr];
            delay_slot_out1 = last_branch;
            empty           = 1'b0;
            almost_empty    = count == ifq_pkg::qptr_t'(1);
            if (!almost_empty) begin
                data_out2    = data_mem[rd_ptr_plus1];
                address_out2 = addr_mem[rd_ptr_plus1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ifq_pkg::qptr_t'(n_wr);
            rd_ptr <= rd_ptr + ifq_pkg::qptr_t'(n_rd);
            count  <= count + ifq_pkg::qptr_t'(n_wr) - ifq_pkg::qptr_t'(n_rd);
        end
    end

    // Slot-1 entry after a branch is its delay slot
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            last_branch <= 1'b0;
        end else if (read_en1) begin
            last_branch <= master_is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            hold_wait  <= 1'b0;
        end else if (flush && !hold_valid) begin
            hold_valid <= count != '0;
            hold_wait  <= count == '0;
        end else if (capture) begin
            hold_valid <= 1'b1;
            hold_wait  <= 1'b0;
        end else if (hold_valid && read_en1) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush && !hold_valid) begin
            hold_data <= data_mem[rd_ptr];
            hold_addr <= addr_mem[rd_ptr];
        end else if (capture) begin
            hold_data <= write_data1;
            hold_addr <= write_address1;
        end
    end

    always_ff @(posedge clk) begin
        if (wa_en && !flush) begin
            data_mem[wr_ptr] <= wa_data;
            addr_mem[wr_ptr] <= wa_addr;
        end
        if (wb_en && !flush) begin
            data_mem[wr_ptr + ifq_pkg::qptr_t'(1)] <= write_data2;
            addr_mem[wr_ptr + ifq_pkg::qptr_t'(1)] <= write_address2;
        end
    end

endmodule

// File: rtl/issue_unit.sv
`timescale 1ns/1ps

`include "ifq_defines.svh"

module issue_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  ifq_pkg::word_t  data_out1,
    input  ifq_pkg::word_t  data_out2,
    input  ifq_pkg::addr_t  address_out1,
    input  ifq_pkg::addr_t  address_out2,
    input  logic            delay_slot_out1,
    input  logic            empty,
    input  logic            almost_empty,
    output logic            read_en1,
    output logic            read_en2,
    output logic            master_is_branch,
    output logic            issue_valid1,
    output ifq_pkg::word_t  issue_instr1,
    output ifq_pkg::addr_t  issue_pc1,
    output logic            issue_delay_slot1,
    output logic            issue_valid2,
    output ifq_pkg::word_t  issue_instr2,
    output ifq_pkg::addr_t  issue_pc2
);

    ifq_pkg::qptr_t avail;
    logic           slave_is_branch;
    logic [1:0]     branch_wait;

    function automatic logic is_branch(input ifq_pkg::word_t instr);
        ifq_pkg::opcode_e op;
        op = ifq_pkg::opcode_e'(instr[`IFQ_OP_MSB:`IFQ_OP_LSB]);
        case (op)
            ifq_pkg::OP_BEQ, ifq_pkg::OP_BNE, ifq_pkg::OP_BLEZ, ifq_pkg::OP_BGTZ,
            ifq_pkg::OP_J, ifq_pkg::OP_JAL, ifq_pkg::OP_REGIMM: is_branch = 1'b1;
            default: is_branch = 1'b0;
        endcase
    endfunction

    assign master_is_branch = is_branch(data_out1);
    assign slave_is_branch  = is_branch(data_out2);

    // Entries the queue can offer this cycle
    assign avail = empty ? ifq_pkg::qptr_t'(0) :
                   almost_empty ? ifq_pkg::qptr_t'(1) : ifq_pkg::qptr_t'(2);

    assign read_en1 = avail != '0 && !stall && branch_wait == 2'd0;
    assign read_en2 = read_en1 && avail >= ifq_pkg::qptr_t'(2)
                      && !master_is_branch && !slave_is_branch;

    // After a branch, leave the delay slot at the head until a redirect could land
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_wait <= 2'd0;
        end else if (read_en1 && master_is_branch) begin
            branch_wait <= 2'd2;
        end else if (branch_wait != 2'd0) begin
            branch_wait <= branch_wait - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid1      <= 1'b0;
            issue_valid2      <= 1'b0;
            issue_delay_slot1 <= 1'b0;
        end else begin
            issue_valid1      <= read_en1;
            issue_valid2      <= read_en2;
            issue_delay_slot1 <= read_en1 && delay_slot_out1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en1) begin
            issue_instr1 <= data_out1;
            issue_pc1    <= address_out1;
        end
        if (read_en2) begin
            issue_instr2 <= data_out2;
            issue_pc2    <= address_out2;
        end
    end

endmodule

// File: rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic            clk,
    input  logic            rst,
    output ifq_pkg::addr_t  imem_addr,
    input  ifq_pkg::word_t  imem_data1,
    input  ifq_pkg::word_t  imem_data2,
    input  logic            redirect,
    input  ifq_pkg::addr_t  redirect_pc,
    input  logic            stall,
    output logic            issue_valid1,
    output ifq_pkg::word_t  issue_instr1,
    output ifq_pkg::addr_t  issue_pc1,
    output logic            issue_delay_slot1,
    output logic            issue_valid2,
    output ifq_pkg::word_t  issue_instr2,
    output ifq_pkg::addr_t  issue_pc2
);

    logic           write_en1;
    logic           write_en2;
    ifq_pkg::word_t write_data1;
    ifq_pkg::word_t write_data2;
    ifq_pkg::addr_t write_address1;
    ifq_pkg::addr_t write_address2;
    logic           full;

    ifq_pkg::word_t data_out1;
    ifq_pkg::word_t data_out2;
    ifq_pkg::addr_t address_out1;
    ifq_pkg::addr_t address_out2;
    logic           delay_slot_out1;
    logic           empty;
    logic           almost_empty;
    logic           read_en1;
    logic           read_en2;
    logic           master_is_branch;

    fetch_unit fetch0 (
        .clk            (clk),
        .rst            (rst),
        .full           (full),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .imem_data1     (imem_data1),
        .imem_data2     (imem_data2),
        .imem_addr      (imem_addr),
        .write_en1      (write_en1),
        .write_en2      (write_en2),
        .write_data1    (write_data1),
        .write_data2    (write_data2),
        .write_address1 (write_address1),
        .write_address2 (write_address2)
    );

    // Redirect doubles as the queue flush
    instruction_fifo ifq0 (
        .clk              (clk),
        .rst              (rst),
        .flush            (redirect),
        .write_en1        (write_en1),
        .write_en2        (write_en2),
        .write_data1      (write_data1),
        .write_data2      (write_data2),
        .write_address1   (write_address1),
        .write_address2   (write_address2),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .data_out1        (data_out1),
        .data_out2        (data_out2),
        .address_out1     (address_out1),
        .address_out2     (address_out2),
        .delay_slot_out1  (delay_slot_out1),
        .empty            (empty),
        .almost_empty     (almost_empty),
        .full             (full)
    );

    issue_unit issue0 (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .data_out1         (data_out1),
        .data_out2         (data_out2),
        .address_out1      (address_out1),
        .address_out2      (address_out2),
        .delay_slot_out1   (delay_slot_out1),
        .empty             (empty),
        .almost_empty      (almost_empty),
        .read_en1          (read_en1),
        .read_en2          (read_en2),
        .master_is_branch  (master_is_branch),
        .issue_valid1      (issue_valid1),
        .issue_instr1      (issue_instr1),
        .issue_pc1         (issue_pc1),
        .issue_delay_slot1 (issue_delay_slot1),
        .issue_valid2      (issue_valid2),
        .issue_instr2      (issue_instr2),
        .issue_pc2         (issue_pc2)
    );

endmodule

// File: tb/frontend_tb.sv
`timescale 1ns/1ps

`include "ifq_defines.svh"

module frontend_tb;

    localparam int TESTDATA_WORDS    = 64;
    localparam int IMEM_WORDS        = 256;
    localparam int SENTINEL_SLOT     = 'h20;
    localparam int TABLE_BASE        = 'h21;
    localparam int STALL_BASE        = 'h30;
    localparam logic [31:0] END_MARK = 32'hffff_ffff;
    localparam int FIRST_ISSUE_LIMIT = 20;
    localparam int RUN_LIMIT         = 500;
    localparam int MIN_HELD_CYCLES   = 8;

    logic           clk;
    logic           rst;
    logic           redirect;
    ifq_pkg::addr_t redirect_pc;
    logic           stall;
    ifq_pkg::addr_t imem_addr;
    ifq_pkg::word_t imem_data1;
    ifq_pkg::word_t imem_data2;
    logic           issue_valid1;
    ifq_pkg::word_t issue_instr1;
    ifq_pkg::addr_t issue_pc1;
    logic           issue_delay_slot1;
    logic           issue_valid2;
    ifq_pkg::word_t issue_instr2;
    ifq_pkg::addr_t issue_pc2;

    logic [31:0]    testdata [TESTDATA_WORDS];
    ifq_pkg::word_t imem [IMEM_WORDS];
    logic [7:0]     fetch_idx;

    // Reference walker state
    ifq_pkg::addr_t exp_pc;
    logic           exp_is_ds;
    logic           jump_pending;
    ifq_pkg::addr_t jump_target;
    ifq_pkg::addr_t sentinel_pc;
    logic           done;

    int             stall_left;
    int             held_cycles;
    int             wait_cycles;
    ifq_pkg::addr_t last_fetch_addr;

    frontend_top dut0 (
        .clk               (clk),
        .rst               (rst),
        .imem_addr         (imem_addr),
        .imem_data1        (imem_data1),
        .imem_data2        (imem_data2),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .stall             (stall),
        .issue_valid1      (issue_valid1),
        .issue_instr1      (issue_instr1),
        .issue_pc1         (issue_pc1),
        .issue_delay_slot1 (issue_delay_slot1),
        .issue_valid2      (issue_valid2),
        .issue_instr2      (issue_instr2),
        .issue_pc2         (issue_pc2)
    );

    always #5 clk = ~clk;

    // Combinational instruction memory returning two consecutive words
    assign fetch_idx  = imem_addr[9:2];
    assign imem_data1 = imem[fetch_idx];
    assign imem_data2 = imem[fetch_idx + 8'd1];

    function automatic logic is_branch_word(input ifq_pkg::word_t w);
        logic [5:0] op;
        op = w[`IFQ_OP_MSB:`IFQ_OP_LSB];
        is_branch_word = op == ifq_pkg::OP_BEQ || op == ifq_pkg::OP_BNE
                         || op == ifq_pkg::OP_BLEZ || op == ifq_pkg::OP_BGTZ
                         || op == ifq_pkg::OP_J || op == ifq_pkg::OP_JAL
                         || op == ifq_pkg::OP_REGIMM;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input ifq_pkg::word_t actual,
                              input ifq_pkg::word_t expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input ifq_pkg::addr_t actual,
                              input ifq_pkg::addr_t expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Branch table entry holds the address in [31:20], taken in [16] and target in [15:0]
    task automatic lookup_branch(input ifq_pkg::addr_t pc, output logic taken,
                                 output ifq_pkg::addr_t target);
        int   i;
        logic found;
        found  = 1'b0;
        taken  = 1'b0;
        target = '0;
        i      = TABLE_BASE;
        while (!found && i < STALL_BASE && testdata[i] != END_MARK) begin
            if (testdata[i][31:20] == pc[11:0]) begin
                found  = 1'b1;
                taken  = testdata[i][16];
                target = {16'h0000, testdata[i][15:0]};
            end
            i++;
        end
        if (!found) begin
            $display("Branch at %h has no entry in the branch table", pc);
            abort_run();
        end
    endtask

    task load_testdata();
        int i;
        for (i = 0; i < TESTDATA_WORDS; i++) begin
            testdata[i] = END_MARK;
        end
        $readmemh("tb/frontend_testdata.mem", testdata);
        sentinel_pc = testdata[SENTINEL_SLOT];
        // Words past the program get a non-branch fill tagged with the word index
        for (i = 0; i < IMEM_WORDS; i++) begin
            if (i <= int'(sentinel_pc[9:2])) begin
                imem[i] = testdata[i];
            end else begin
                imem[i] = {6'b001001, 26'(i)};
            end
        end
    endtask

    task consume_expected(input string slot, input ifq_pkg::addr_t pc,
                          input ifq_pkg::word_t instr);
        ifq_pkg::word_t exp_word;
        ifq_pkg::addr_t next_pc;
        logic           taken;
        ifq_pkg::addr_t target;
        exp_word = imem[exp_pc[9:2]];
        check_addr({"issue_pc", slot}, pc, exp_pc);
        check_word({"issue_instr", slot}, instr, exp_word);
        if (exp_is_ds && jump_pending) begin
            next_pc      = jump_target;
            jump_pending = 1'b0;
        end else begin
            next_pc = exp_pc + 32'd4;
        end
        exp_is_ds = is_branch_word(exp_word);
        if (exp_is_ds) begin
            lookup_branch(exp_pc, taken, target);
            jump_pending = taken;
            jump_target  = target;
        end
        if (exp_pc == sentinel_pc) begin
            done = 1'b1;
        end
        exp_pc = next_pc;
    endtask

    // Stall entry holds the trigger pc in [31:16] and the cycle count in [15:0]
    task update_stall();
        int i;
        if (stall_left != 0) begin
            stall_left--;
            if (stall_left == 0) begin
                stall = 1'b0;
            end
        end
        i = STALL_BASE;
        while (i < TESTDATA_WORDS && testdata[i] != END_MARK) begin
            if ((issue_valid1 && testdata[i][31:16] == issue_pc1[15:0])
                || (issue_valid2 && testdata[i][31:16] == issue_pc2[15:0])) begin
                stall      = 1'b1;
                stall_left = testdata[i][15:0];
            end
            i++;
        end
    endtask

    task sample_cycle();
        logic           taken;
        ifq_pkg::addr_t target;
        ifq_pkg::addr_t slot1_pc;
        if (stall) begin
            check_bit("issue_valid1", issue_valid1, 1'b0);
            check_bit("issue_valid2", issue_valid2, 1'b0);
            if (imem_addr == last_fetch_addr) begin
                held_cycles++;
            end
        end
        last_fetch_addr = imem_addr;
        redirect        = 1'b0;
        slot1_pc        = exp_pc;
        if (issue_valid1) begin
            check_bit("issue_delay_slot1", issue_delay_slot1, exp_is_ds);
            consume_expected("1", issue_pc1, issue_instr1);
        end
        if (issue_valid2 && !done) begin
            check_bit("issue_valid1", issue_valid1, 1'b1);
            check_bit("branch in issue_instr1 with slot 2", is_branch_word(issue_instr1), 1'b0);
            check_bit("branch in issue_instr2", is_branch_word(issue_instr2), 1'b0);
            check_addr("issue_pc2", issue_pc2, slot1_pc + 32'd4);
            consume_expected("2", issue_pc2, issue_instr2);
        end
        // Taken branch resolves one cycle after it issues
        if (issue_valid1 && is_branch_word(issue_instr1)) begin
            lookup_branch(issue_pc1, taken, target);
            if (taken) begin
                redirect    = 1'b1;
                redirect_pc = target;
            end
        end
        update_stall();
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        redirect        = 1'b0;
        redirect_pc     = '0;
        stall           = 1'b0;
        exp_pc          = `IFQ_RESET_PC;
        exp_is_ds       = 1'b0;
        jump_pending    = 1'b0;
        jump_target     = '0;
        done            = 1'b0;
        stall_left      = 0;
        held_cycles     = 0;
        last_fetch_addr = '0;
        load_testdata();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wait_cycles = 0;
        while (!issue_valid1) begin
            if (wait_cycles == FIRST_ISSUE_LIMIT) begin
                $display("No instruction issued within %0d cycles after reset",
                         FIRST_ISSUE_LIMIT);
                abort_run();
            end
            @(negedge clk);
            wait_cycles++;
        end

        wait_cycles = 0;
        while (!done) begin
            if (wait_cycles == RUN_LIMIT) begin
                $display("Sentinel instruction at %h did not issue within %0d cycles",
                         sentinel_pc, RUN_LIMIT);
                abort_run();
            end
            sample_cycle();
            @(negedge clk);
            wait_cycles++;
        end

        if (held_cycles < MIN_HELD_CYCLES) begin
            $display("Fetch address never held under stall, queue never reached full");
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: tb/frontend_testdata.mem
// @00 program words, one per line; @20 address of the last (sentinel) word
// @21 branch table aaaftttt (address, taken, target); @30 stall table ppppllll (pc, cycles)
@00
24010001
24020002
24030003
10220002  // 0x0c beq taken, last word of a pair
24040004
24050005
24060006  // 0x18 target, long stall after it issues
14430003  // 0x1c bne not taken
24080008
24090009
0800000d  // 0x28 j taken
240b000b
240c000c
240d000d  // 0x34 odd-word target
240e000e
1c800002  // 0x3c bgtz taken, stalled while its delay slot waits
24100010
24110011
24120012  // 0x48 target
18a00001  // 0x4c blez not taken
24140014
24150015
24160016  // 0x58 sentinel
@20
00000058
@21
00c10018
01c00000
02810034
03c10048
04c00000
ffffffff
@30
00180028
003c0003
ffffffff

// File: sim.f
+incdir+common
common/ifq_pkg.sv
fetch/fetch_unit.sv
fetch/instruction_fifo.sv
rtl/issue_unit.sv
rtl/frontend_top.sv
tb/frontend_tb.sv

// File: Bender.yml
package:
  name: ifq_frontend

sources:
  - include_dirs:
      - common
    files:
      - common/ifq_pkg.sv
      - fetch/fetch_unit.sv
      - fetch/instruction_fifo.sv
      - rtl/issue_unit.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/frontend_tb.sv
